//--- roce_defines.svh
// build constants for the RoCE ACK receiver; ICRC check enable must be 0 or 1
`ifndef ROCE_DEFINES_SVH
`define ROCE_DEFINES_SVH

// well-known RoCEv2 UDP destination port
`define ROCE_UDP_PORT 16'd4791

// BTH opcode of an RC acknowledge
`define ROCE_OP_RC_ACK 8'h11

// 1 compares received against computed ICRC, 0 releases every ACK
`define ROCE_ICRC_CHECK 1'b1

// payload datapath width in bits
// field extraction assumes 64, three words cover BTH, AETH and ICRC
`define ROCE_DATA_W 64

`endif

//--- roce_pkg.sv
// shared field types; widths follow BTH/AETH layout and assume a 64-bit payload word
`include "roce_defines.svh"

package roce_pkg;

  // payload beat and its byte enables
  typedef logic [`ROCE_DATA_W-1:0]   roce_data_t;
  typedef logic [`ROCE_DATA_W/8-1:0] roce_keep_t;

  // BTH fields
  typedef logic [7:0]  opcode_t;
  typedef logic [15:0] pkey_t;
  typedef logic [23:0] qpn_t;
  // also carries the AETH MSN
  typedef logic [23:0] psn_t;

  // AETH syndrome
  typedef logic [7:0]  syndrome_t;

  typedef logic [31:0] icrc_t;
  typedef logic [15:0] udp_port_t;

  // header word index, 0 to 2
  typedef logic [1:0]  hdr_word_t;

  // frame receive states
  typedef enum logic [1:0] {
    IDLE,
    READ_HDR,
    CHECK,
    DISCARD
  } rx_state_t;

endpackage

//--- roce_hdr_capture.sv
// field registers for one frame; values are held until the next header store
`timescale 1ns/1ps
`include "roce_defines.svh"

module roce_hdr_capture (
  input  logic                clk,
  input  logic                rst,
  input  logic                store_hdr,
  input  logic                store_word,
  input  roce_pkg::hdr_word_t word_sel,
  input  roce_pkg::udp_port_t udp_dest_port,
  input  roce_pkg::icrc_t     computed_icrc,
  input  roce_pkg::roce_data_t payload_tdata,
  output roce_pkg::opcode_t   bth_op_code,
  output roce_pkg::pkey_t     bth_p_key,
  output roce_pkg::qpn_t      bth_dest_qp,
  output logic                bth_ack_req,
  output roce_pkg::psn_t      bth_psn,
  output roce_pkg::syndrome_t aeth_syndrome,
  output roce_pkg::psn_t      aeth_msn,
  output logic                is_ack,
  output logic                icrc_match
);

  // from the UDP header beat
  roce_pkg::udp_port_t dest_port_q;
  roce_pkg::icrc_t     computed_icrc_q;
  // from payload word 2
  roce_pkg::icrc_t     received_icrc_q;

  // opcode and port cleared so the verdict reads false out of reset
  always_ff @(posedge clk) begin
    if (rst) begin
      dest_port_q <= '0;
      bth_op_code <= '0;
    end else begin
      if (store_hdr) begin
        dest_port_q <= udp_dest_port;
      end
      if (store_word && word_sel == 2'd0) begin
        bth_op_code <= payload_tdata[7:0];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (store_hdr) begin
      computed_icrc_q <= computed_icrc;
    end
    if (store_word) begin
      case (word_sel)
        2'd0: begin
          // lane 1 holds SE/M/pad/version, not kept
          bth_p_key   <= {payload_tdata[23:16], payload_tdata[31:24]};
          // lane 4 reserved
          bth_dest_qp <= {payload_tdata[47:40], payload_tdata[55:48], payload_tdata[63:56]};
        end
        2'd1: begin
          // ack request is the top bit of lane 0
          bth_ack_req   <= payload_tdata[7];
          bth_psn       <= {payload_tdata[15:8], payload_tdata[23:16], payload_tdata[31:24]};
          aeth_syndrome <= payload_tdata[39:32];
          aeth_msn      <= {payload_tdata[47:40], payload_tdata[55:48], payload_tdata[63:56]};
        end
        2'd2: begin
          // lanes 0-3, msb first on the wire
          received_icrc_q <= {payload_tdata[7:0], payload_tdata[15:8],
                              payload_tdata[23:16], payload_tdata[31:24]};
        end
        default: begin
          // index 3 never selected
        end
      endcase
    end
  end

  // drop unless RC ACK on the RoCE port
  assign is_ack = (bth_op_code == `ROCE_OP_RC_ACK) && (dest_port_q == `ROCE_UDP_PORT);

  // meaningful only once word 2 is stored
  assign icrc_match = (received_icrc_q == computed_icrc_q);

endmodule

//--- roce_ack_rx_ctrl.sv
// one frame at a time; a header is taken only in IDLE with both outputs drained
`timescale 1ns/1ps

module roce_ack_rx_ctrl (
  input  logic                clk,
  input  logic                rst,
  input  logic                udp_hdr_valid,
  input  logic                payload_tvalid,
  input  logic                payload_tlast,
  input  logic                is_ack,
  input  logic                pending,
  output logic                udp_hdr_ready,
  output logic                payload_tready,
  output logic                store_hdr,
  output logic                store_word,
  output roce_pkg::hdr_word_t word_sel,
  output logic                check,
  output logic                error_not_ack,
  output logic                error_early_term,
  output logic                busy
);

  roce_pkg::rx_state_t state;
  roce_pkg::rx_state_t state_next;
  roce_pkg::hdr_word_t word_idx;
  roce_pkg::hdr_word_t word_idx_next;
  // word 2 already carried last
  logic last_seen;
  logic last_seen_next;
  logic hdr_ready_next;
  logic tready_next;
  logic not_ack_next;
  logic early_next;
  logic payload_xfer;

  assign payload_xfer = payload_tvalid && payload_tready;

  always_comb begin
    state_next     = state;
    word_idx_next  = word_idx;
    last_seen_next = last_seen;
    tready_next    = payload_tready;
    not_ack_next   = 1'b0;
    early_next     = 1'b0;
    store_hdr      = 1'b0;
    store_word     = 1'b0;

    case (state)
      roce_pkg::IDLE: begin
        if (udp_hdr_valid && udp_hdr_ready) begin
          store_hdr      = 1'b1;
          word_idx_next  = 2'd0;
          last_seen_next = 1'b0;
          tready_next    = 1'b1;
          state_next     = roce_pkg::READ_HDR;
        end
      end
      roce_pkg::READ_HDR: begin
        if (payload_xfer) begin
          store_word = 1'b1;
          if (word_idx != 2'd2) begin
            // last before word 2 is a short frame
            if (payload_tlast) begin
              early_next  = 1'b1;
              tready_next = 1'b0;
              state_next  = roce_pkg::IDLE;
            end else begin
              word_idx_next = word_idx + 2'd1;
            end
          end else if (!is_ack) begin
            // not for us, flush the rest
            not_ack_next = 1'b1;
            tready_next  = !payload_tlast;
            state_next   = payload_tlast ? roce_pkg::IDLE : roce_pkg::DISCARD;
          end else begin
            last_seen_next = payload_tlast;
            tready_next    = !payload_tlast;
            state_next     = roce_pkg::CHECK;
          end
        end
      end
      roce_pkg::CHECK: begin
        // one cycle only, payload may still move meanwhile
        if (last_seen) begin
          state_next = roce_pkg::IDLE;
        end else if (payload_xfer && payload_tlast) begin
          tready_next = 1'b0;
          state_next  = roce_pkg::IDLE;
        end else begin
          state_next = roce_pkg::DISCARD;
        end
      end
      roce_pkg::DISCARD: begin
        if (payload_xfer && payload_tlast) begin
          tready_next = 1'b0;
          state_next  = roce_pkg::IDLE;
        end
      end
      default: begin
        state_next = roce_pkg::IDLE;
      end
    endcase

    // check may raise pending on this edge, so hold off one more cycle
    hdr_ready_next = (state_next == roce_pkg::IDLE) && !pending && !check;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state            <= roce_pkg::IDLE;
      word_idx         <= 2'd0;
      last_seen        <= 1'b0;
      udp_hdr_ready    <= 1'b0;
      payload_tready   <= 1'b0;
      error_not_ack    <= 1'b0;
      error_early_term <= 1'b0;
      busy             <= 1'b0;
    end else begin
      state            <= state_next;
      word_idx         <= word_idx_next;
      last_seen        <= last_seen_next;
      udp_hdr_ready    <= hdr_ready_next;
      payload_tready   <= tready_next;
      error_not_ack    <= not_ack_next;
      error_early_term <= early_next;
      busy             <= (state_next != roce_pkg::IDLE);
    end
  end

  assign word_sel = word_idx;

  // release samples the verdict during this cycle
  assign check = (state == roce_pkg::CHECK);

endmodule

//--- roce_ack_release.sv
// holds BTH/AETH valids until each own ready; a new check only comes once both are clear
`timescale 1ns/1ps
`include "roce_defines.svh"

module roce_ack_release (
  input  logic clk,
  input  logic rst,
  input  logic check,
  input  logic icrc_match,
  input  logic bth_ready,
  input  logic aeth_ready,
  output logic bth_valid,
  output logic aeth_valid,
  output logic pending,
  output logic error_icrc
);

  logic check_ok;

  // with the check disabled every ACK passes
  assign check_ok = (`ROCE_ICRC_CHECK == 1'b0) || icrc_match;

  always_ff @(posedge clk) begin
    if (rst) begin
      bth_valid  <= 1'b0;
      aeth_valid <= 1'b0;
      error_icrc <= 1'b0;
    end else begin
      // single-cycle mismatch flag
      error_icrc <= check && !check_ok;

      if (check && check_ok) begin
        bth_valid <= 1'b1;
      end else if (bth_ready) begin
        bth_valid <= 1'b0;
      end

      // drains independently of bth
      if (check && check_ok) begin
        aeth_valid <= 1'b1;
      end else if (aeth_ready) begin
        aeth_valid <= 1'b0;
      end
    end
  end

  // either header still owed downstream
  assign pending = bth_valid || aeth_valid;

endmodule

//--- roce_ack_rx.sv
// RoCE ACK receiver top; tkeep and tuser are accepted but ignored, ICRC comes precomputed
`timescale 1ns/1ps

module roce_ack_rx (
  input  logic                 clk,
  input  logic                 rst,
  // UDP header beat
  input  logic                 udp_hdr_valid,
  output logic                 udp_hdr_ready,
  input  roce_pkg::udp_port_t  udp_dest_port,
  input  roce_pkg::icrc_t      computed_icrc,
  // payload stream
  input  roce_pkg::roce_data_t payload_tdata,
  input  roce_pkg::roce_keep_t payload_tkeep,
  input  logic                 payload_tvalid,
  output logic                 payload_tready,
  input  logic                 payload_tlast,
  input  logic                 payload_tuser,
  // BTH out
  output logic                 bth_valid,
  input  logic                 bth_ready,
  output roce_pkg::opcode_t    bth_op_code,
  output roce_pkg::pkey_t      bth_p_key,
  output roce_pkg::psn_t       bth_psn,
  output roce_pkg::qpn_t       bth_dest_qp,
  output logic                 bth_ack_req,
  // AETH out
  output logic                 aeth_valid,
  input  logic                 aeth_ready,
  output roce_pkg::syndrome_t  aeth_syndrome,
  output roce_pkg::psn_t       aeth_msn,
  // status
  output logic                 busy,
  output logic                 error_not_ack,
  output logic                 error_icrc,
  output logic                 error_early_term
);

  logic                store_hdr;
  logic                store_word;
  roce_pkg::hdr_word_t word_sel;
  logic                is_ack;
  logic                icrc_match;
  logic                check;
  logic                pending;

  // payload_tkeep and payload_tuser have no consumer, header words are always full

  roce_hdr_capture u_capture (
    .clk           (clk),
    .rst           (rst),
    .store_hdr     (store_hdr),
    .store_word    (store_word),
    .word_sel      (word_sel),
    .udp_dest_port (udp_dest_port),
    .computed_icrc (computed_icrc),
    .payload_tdata (payload_tdata),
    .bth_op_code   (bth_op_code),
    .bth_p_key     (bth_p_key),
    .bth_dest_qp   (bth_dest_qp),
    .bth_ack_req   (bth_ack_req),
    .bth_psn       (bth_psn),
    .aeth_syndrome (aeth_syndrome),
    .aeth_msn      (aeth_msn),
    .is_ack        (is_ack),
    .icrc_match    (icrc_match)
  );

  roce_ack_rx_ctrl u_ctrl (
    .clk              (clk),
    .rst              (rst),
    .udp_hdr_valid    (udp_hdr_valid),
    .payload_tvalid   (payload_tvalid),
    .payload_tlast    (payload_tlast),
    .is_ack           (is_ack),
    .pending          (pending),
    .udp_hdr_ready    (udp_hdr_ready),
    .payload_tready   (payload_tready),
    .store_hdr        (store_hdr),
    .store_word       (store_word),
    .word_sel         (word_sel),
    .check            (check),
    .error_not_ack    (error_not_ack),
    .error_early_term (error_early_term),
    .busy             (busy)
  );

  roce_ack_release u_release (
    .clk        (clk),
    .rst        (rst),
    .check      (check),
    .icrc_match (icrc_match),
    .bth_ready  (bth_ready),
    .aeth_ready (aeth_ready),
    .bth_valid  (bth_valid),
    .aeth_valid (aeth_valid),
    .pending    (pending),
    .error_icrc (error_icrc)
  );

endmodule

//--- tb_roce_ack_rx.sv
// assumes ROCE_ICRC_CHECK is 1; gaps and ready delays come from $random seeded with 71
`timescale 1ns/1ps
`include "roce_defines.svh"

module tb_roce_ack_rx;

  localparam int rows = 9;
  // expected outcome per row
  localparam int out_release = 0;
  localparam int out_not_ack = 1;
  localparam int out_icrc    = 2;
  localparam int out_early   = 3;

  logic                 clk = 1'b0;
  logic                 rst;
  logic                 udp_hdr_valid;
  logic                 udp_hdr_ready;
  roce_pkg::udp_port_t  udp_dest_port;
  roce_pkg::icrc_t      computed_icrc;
  roce_pkg::roce_data_t payload_tdata;
  roce_pkg::roce_keep_t payload_tkeep;
  logic                 payload_tvalid;
  logic                 payload_tready;
  logic                 payload_tlast;
  logic                 payload_tuser;
  logic                 bth_valid;
  logic                 bth_ready = 1'b0;
  roce_pkg::opcode_t    bth_op_code;
  roce_pkg::pkey_t      bth_p_key;
  roce_pkg::psn_t       bth_psn;
  roce_pkg::qpn_t       bth_dest_qp;
  logic                 bth_ack_req;
  logic                 aeth_valid;
  logic                 aeth_ready = 1'b0;
  roce_pkg::syndrome_t  aeth_syndrome;
  roce_pkg::psn_t       aeth_msn;
  logic                 busy;
  logic                 error_not_ack;
  logic                 error_icrc;
  logic                 error_early_term;

  // stimulus table, one frame per row
  string               t_name [rows];
  roce_pkg::opcode_t   t_op [rows];
  roce_pkg::udp_port_t t_port [rows];
  roce_pkg::icrc_t     t_rx [rows];
  roce_pkg::icrc_t     t_comp [rows];
  int                  t_words [rows];
  int                  t_delay [rows];
  int                  t_outcome [rows];
  roce_pkg::pkey_t     t_pkey [rows];
  roce_pkg::qpn_t      t_qp [rows];
  logic                t_ackreq [rows];
  roce_pkg::psn_t      t_psn [rows];
  roce_pkg::syndrome_t t_syn [rows];
  roce_pkg::psn_t      t_msn [rows];

  integer seed;
  int cycle = 0;
  int limit = 0;
  int task_errs = 0;
  int mon_errs = 0;
  int rows_ok = 0;
  int rows_bad = 0;
  // running totals kept by the monitor
  int na_total = 0;
  int ic_total = 0;
  int et_total = 0;
  int bth_xfers = 0;
  int aeth_xfers = 0;
  int bth_rise_cycle = 0;
  int aeth_rise_cycle = 0;
  logic bth_seen = 1'b0;
  logic aeth_seen = 1'b0;
  int bth_hold = 0;
  int aeth_hold = 0;
  // set per frame by the stimulus task
  int cur_row = 0;
  int row_delay = 0;
  int row_aeth_delay = 0;

  roce_ack_rx dut (
    .clk              (clk),
    .rst              (rst),
    .udp_hdr_valid    (udp_hdr_valid),
    .udp_hdr_ready    (udp_hdr_ready),
    .udp_dest_port    (udp_dest_port),
    .computed_icrc    (computed_icrc),
    .payload_tdata    (payload_tdata),
    .payload_tkeep    (payload_tkeep),
    .payload_tvalid   (payload_tvalid),
    .payload_tready   (payload_tready),
    .payload_tlast    (payload_tlast),
    .payload_tuser    (payload_tuser),
    .bth_valid        (bth_valid),
    .bth_ready        (bth_ready),
    .bth_op_code      (bth_op_code),
    .bth_p_key        (bth_p_key),
    .bth_psn          (bth_psn),
    .bth_dest_qp      (bth_dest_qp),
    .bth_ack_req      (bth_ack_req),
    .aeth_valid       (aeth_valid),
    .aeth_ready       (aeth_ready),
    .aeth_syndrome    (aeth_syndrome),
    .aeth_msn         (aeth_msn),
    .busy             (busy),
    .error_not_ack    (error_not_ack),
    .error_icrc       (error_icrc),
    .error_early_term (error_early_term)
  );

  // 4 ns period
  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  task automatic add_row(input int r, input string name, input roce_pkg::opcode_t op,
                         input roce_pkg::udp_port_t port, input roce_pkg::icrc_t rx,
                         input roce_pkg::icrc_t comp, input int words, input int delay,
                         input int outcome, input roce_pkg::pkey_t pkey,
                         input roce_pkg::qpn_t qp, input logic ackreq,
                         input roce_pkg::psn_t psn, input roce_pkg::syndrome_t syn,
                         input roce_pkg::psn_t msn);
    t_name[r]    = name;
    t_op[r]      = op;
    t_port[r]    = port;
    t_rx[r]      = rx;
    t_comp[r]    = comp;
    t_words[r]   = words;
    t_delay[r]   = delay;
    t_outcome[r] = outcome;
    t_pkey[r]    = pkey;
    t_qp[r]      = qp;
    t_ackreq[r]  = ackreq;
    t_psn[r]     = psn;
    t_syn[r]     = syn;
    t_msn[r]     = msn;
  endtask

  task automatic fill_table();
    add_row(0, "ack basic", `ROCE_OP_RC_ACK, `ROCE_UDP_PORT, 32'hcafe_f00d, 32'hcafe_f00d,
            3, 0, out_release, 16'hffff, 24'h12_3456, 1'b1, 24'hab_cdef, 8'h00, 24'h00_0102);
    add_row(1, "wrong opcode", 8'h0a, `ROCE_UDP_PORT, 32'h1111_2222, 32'h1111_2222,
            3, 0, out_not_ack, 16'h8001, 24'h00_0042, 1'b0, 24'h00_0010, 8'h00, 24'h00_0001);
    // longer frame so the drop path flushes through DISCARD
    add_row(2, "wrong port", `ROCE_OP_RC_ACK, 16'd4792, 32'h3333_4444, 32'h3333_4444,
            5, 0, out_not_ack, 16'h8002, 24'h00_0043, 1'b1, 24'h00_0020, 8'h00, 24'h00_0002);
    add_row(3, "icrc mismatch", `ROCE_OP_RC_ACK, `ROCE_UDP_PORT, 32'h5566_7788, 32'h5566_7789,
            3, 0, out_icrc, 16'h8003, 24'h00_0044, 1'b1, 24'h00_0030, 8'h00, 24'h00_0003);
    add_row(4, "last on word 1", `ROCE_OP_RC_ACK, `ROCE_UDP_PORT, 32'h0, 32'h0,
            2, 0, out_early, 16'h8004, 24'h00_0045, 1'b0, 24'h00_0040, 8'h00, 24'h00_0004);
    add_row(5, "last on word 0", `ROCE_OP_RC_ACK, `ROCE_UDP_PORT, 32'h0, 32'h0,
            1, 0, out_early, 16'h8005, 24'h00_0046, 1'b0, 24'h00_0050, 8'h00, 24'h00_0005);
    add_row(6, "back-pressure", `ROCE_OP_RC_ACK, `ROCE_UDP_PORT, 32'h0bad_beef, 32'h0bad_beef,
            3, 6, out_release, 16'h1234, 24'hfe_dcba, 1'b1, 24'h98_7654, 8'h1f, 24'h55_aa55);
    add_row(7, "long frame with gaps", `ROCE_OP_RC_ACK, `ROCE_UDP_PORT, 32'h9abc_def0,
            32'h9abc_def0, 6, 2, out_release, 16'h7fff, 24'h00_0001, 1'b0, 24'hff_fffe,
            8'h60, 24'h80_0000);
    add_row(8, "ack after long frame", `ROCE_OP_RC_ACK, `ROCE_UDP_PORT, 32'h0123_4567,
            32'h0123_4567, 3, 0, out_release, 16'h0001, 24'h80_0081, 1'b1, 24'h00_0000,
            8'h20, 24'h7f_ffff);
  endtask

  // lane 0 is the first wire byte, multi-byte fields big-endian
  function automatic roce_pkg::roce_data_t frame_word(input int r, input int w,
                                                      input logic [31:0] filler);
    roce_pkg::roce_data_t word;
    case (w)
      0: word = {t_qp[r][7:0], t_qp[r][15:8], t_qp[r][23:16], 8'h00,
                 t_pkey[r][7:0], t_pkey[r][15:8], 8'h40, t_op[r]};
      1: word = {t_msn[r][7:0], t_msn[r][15:8], t_msn[r][23:16], t_syn[r],
                 t_psn[r][7:0], t_psn[r][15:8], t_psn[r][23:16], t_ackreq[r], 7'h00};
      2: word = {filler, t_rx[r][7:0], t_rx[r][15:8], t_rx[r][23:16], t_rx[r][31:24]};
      default: word = {filler, ~filler};
    endcase
    return word;
  endfunction

  task automatic check_count(input int r, input string what, input int got, input int want);
    assert (got == want) else begin
      $display("mismatch at %0t: row %0d %s is %0d, expected %0d", $time, r, what, got, want);
      task_errs++;
    end
  endtask

  task automatic run_frame(input int r);
    int w;
    int gap;
    int x2_cycle;
    int na0;
    int ic0;
    int et0;
    int bx0;
    int ax0;
    int err0;
    int want_rel;
    logic [31:0] filler;
    na0 = na_total;
    ic0 = ic_total;
    et0 = et_total;
    bx0 = bth_xfers;
    ax0 = aeth_xfers;
    err0 = task_errs + mon_errs;
    x2_cycle = -100;
    want_rel = (t_outcome[r] == out_release) ? 1 : 0;
    cur_row = r;
    row_delay = t_delay[r];
    // aeth drains a random few cycles after bth
    row_aeth_delay = (t_delay[r] == 0) ? 0 : t_delay[r] + int'($unsigned($random(seed)) % 3);
    @(posedge clk);
    udp_hdr_valid <= 1'b1;
    udp_dest_port <= t_port[r];
    computed_icrc <= t_comp[r];
    do @(posedge clk); while (!udp_hdr_ready);
    udp_hdr_valid <= 1'b0;
    for (w = 0; w < t_words[r]; w++) begin
      gap = int'($unsigned($random(seed)) % 3);
      filler = $random(seed);
      if (gap > 0) begin
        payload_tvalid <= 1'b0;
        repeat (gap) @(posedge clk);
      end
      payload_tvalid <= 1'b1;
      payload_tdata  <= frame_word(r, w, filler);
      payload_tlast  <= (w == t_words[r] - 1);
      do @(posedge clk); while (!payload_tready);
      if (w == 2) begin
        x2_cycle = cycle;
      end
      assert (busy) else begin
        $display("row %0d: busy was low while word %0d was transferred", r, w);
        task_errs++;
      end
    end
    payload_tvalid <= 1'b0;
    payload_tlast  <= 1'b0;
    // frame done once busy drops and both outputs have drained
    do @(posedge clk); while (busy || bth_valid || aeth_valid);
    repeat (3) @(posedge clk);
    @(negedge clk);
    check_count(r, "not-ack pulses", na_total - na0, (t_outcome[r] == out_not_ack) ? 1 : 0);
    check_count(r, "icrc pulses", ic_total - ic0, (t_outcome[r] == out_icrc) ? 1 : 0);
    check_count(r, "early-term pulses", et_total - et0, (t_outcome[r] == out_early) ? 1 : 0);
    check_count(r, "bth transfers", bth_xfers - bx0, want_rel);
    check_count(r, "aeth transfers", aeth_xfers - ax0, want_rel);
    if (want_rel == 1) begin
      check_count(r, "bth valid latency", bth_rise_cycle - x2_cycle, 2);
      check_count(r, "aeth valid latency", aeth_rise_cycle - x2_cycle, 2);
    end
    assert (!payload_tready && !busy) else begin
      $display("row %0d: payload not closed after last, tready %b busy %b",
               r, payload_tready, busy);
      task_errs++;
    end
    if (task_errs + mon_errs == err0) begin
      rows_ok++;
      $display("row %0d %s: ok", r, t_name[r]);
    end else begin
      rows_bad++;
      $display("row %0d %s: %0d errors", r, t_name[r], task_errs + mon_errs - err0);
    end
  endtask

  // pulse counts, valid edges, field values and ready generation
  always @(posedge clk) begin
    if (!rst) begin
      if (error_not_ack) na_total++;
      if (error_icrc) ic_total++;
      if (error_early_term) et_total++;
      if (bth_valid && !bth_seen) bth_rise_cycle = cycle;
      if (aeth_valid && !aeth_seen) aeth_rise_cycle = cycle;
      if (bth_valid && bth_ready) bth_xfers++;
      if (aeth_valid && aeth_ready) aeth_xfers++;
      // fields must hold the row's values the whole time valid is up
      if (bth_valid) begin
        assert (bth_op_code == t_op[cur_row] && bth_p_key == t_pkey[cur_row] &&
                bth_dest_qp == t_qp[cur_row] && bth_ack_req == t_ackreq[cur_row] &&
                bth_psn == t_psn[cur_row]) else begin
          $display("mismatch at %0t: row %0d bth op %h pkey %h qp %h ack %b psn %h", $time,
                   cur_row, bth_op_code, bth_p_key, bth_dest_qp, bth_ack_req, bth_psn);
          mon_errs++;
        end
      end
      if (aeth_valid) begin
        assert (aeth_syndrome == t_syn[cur_row] && aeth_msn == t_msn[cur_row]) else begin
          $display("mismatch at %0t: row %0d aeth syndrome %h msn %h", $time, cur_row,
                   aeth_syndrome, aeth_msn);
          mon_errs++;
        end
      end
      assert (!((bth_valid || aeth_valid) && udp_hdr_ready)) else begin
        $display("header ready at %0t while a released frame was still pending", $time);
        mon_errs++;
      end
    end
    bth_seen = bth_valid;
    aeth_seen = aeth_valid;
    // ready stays low for the row's delay once valid is up
    bth_hold = bth_valid ? bth_hold + 1 : 0;
    aeth_hold = aeth_valid ? aeth_hold + 1 : 0;
    bth_ready <= (bth_hold >= row_delay);
    aeth_ready <= (aeth_hold >= row_aeth_delay);
  end

  // limit is filled at time zero, before the first edge
  initial begin
    @(posedge clk);
    while (cycle < limit) begin
      @(posedge clk);
    end
    $display("timeout: run did not finish within %0d cycles", limit);
    $display("test failed");
    $finish;
  end

  initial begin
    int r;
    rst            <= 1'b1;
    udp_hdr_valid  <= 1'b0;
    udp_dest_port  <= '0;
    computed_icrc  <= '0;
    payload_tdata  <= '0;
    payload_tkeep  <= '1;
    payload_tvalid <= 1'b0;
    payload_tlast  <= 1'b0;
    payload_tuser  <= 1'b0;
    seed = 71;
    fill_table();
    for (r = 0; r < rows; r++) begin
      limit += t_words[r] + t_delay[r] + 20;
    end
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    for (r = 0; r < rows; r++) begin
      run_frame(r);
    end
    $display("rows %0d, passed %0d, failed %0d, errors %0d", rows, rows_ok, rows_bad,
             task_errs + mon_errs);
    if (task_errs + mon_errs == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

//--- compile.f
+incdir+.
roce_pkg.sv
roce_hdr_capture.sv
roce_ack_rx_ctrl.sv
roce_ack_release.sv
roce_ack_rx.sv
tb_roce_ack_rx.sv

//--- run_sim.sh
#!/bin/sh
# Verilator build and run of the RoCE ACK receiver testbench

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f compile.f --top-module tb_roce_ack_rx -o sim_tb
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/sim_tb)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

# pass only when the testbench printed its pass line
if printf '%s\n' "$sim_out" | grep -qx "test passed"; then
  exit 0
fi
echo "pass line not found in simulation output"
exit 1
